// File: design/lcd_config.svh
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

// cycles per step are 2**LCD_STEP_BITS, use about 17 on hardware
`define LCD_STEP_BITS 4

`define LCD_FRAME_STEPS 78
`define LCD_UP_FIRST 12      // first step of the upper row
`define LCD_ADDR_FIRST 44    // set address 0x40 takes two steps
`define LCD_DO_FIRST 46      // first step of the lower row

`define LCD_COLS 16
`define LCD_BLANK 8'h20

`endif

// File: design/lcdPkg.sv
`default_nettype none

package lcdPkg;

`include "lcd_config.svh"

    // ==================================================
    // bus operation carried by one step
    // ==================================================
    typedef enum logic [1:0]
    {
        opIdle = 2'd0,  // rw high, e held low
        opCmd  = 2'd1,  // command nibble with rs low
        opData = 2'd2   // data nibble with rs high
    } lcdOp_e;

    // ==================================================
    // text types
    // ==================================================
    typedef logic [7:0] lcdChar_t;  // one character code

    // column 0 sits in the top byte
    typedef logic [`LCD_COLS*8-1:0] lcdRow_t;

endpackage

`default_nettype wire

// File: design/lcdRowStore.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcdRowStore import lcdPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     charWrite,
    input  wire logic     charRow,
    input  wire logic [3:0] charCol,
    input  wire lcdChar_t charCode,
    input  wire logic     frameEnd,
    output lcdRow_t       upRow,
    output lcdRow_t       doRow
);

    lcdRow_t upLive;
    lcdRow_t doLive;

    // ==================================================
    // live text, written by the host
    // ==================================================
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            upLive <= {`LCD_COLS{`LCD_BLANK}};
            doLive <= {`LCD_COLS{`LCD_BLANK}};
        end
        else if (charWrite)
        begin
            // column 0 lands in the top byte of the row
            if (charRow)
            begin
                doLive[(`LCD_COLS - 1 - charCol) * 8 +: 8] <= charCode;
            end
            else
            begin
                upLive[(`LCD_COLS - 1 - charCol) * 8 +: 8] <= charCode;
            end
        end
    end

    // ==================================================
    // frame snapshot
    // ==================================================
    // taken in the last cycle of a frame so the next frame never mixes text
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            upRow <= {`LCD_COLS{`LCD_BLANK}};
            doRow <= {`LCD_COLS{`LCD_BLANK}};
        end
        else if (frameEnd)
        begin
            upRow <= upLive;  // a write in this cycle waits one more frame
            doRow <= doLive;
        end
    end

endmodule

`default_nettype wire

// File: design/lcdStepTimer.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcdStepTimer
(
    input  wire logic       clk,
    input  wire logic       rst,
    output logic [6:0]      stepIdx,
    output logic            stepStart,
    output logic            enWindow,
    output logic            frameEnd
);

    logic [`LCD_STEP_BITS-1:0] subCnt;
    logic                      lastSub;

    assign lastSub = &subCnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            subCnt  <= '0;
            stepIdx <= '0;
        end
        else
        begin
            subCnt <= subCnt + 1'b1;  // wraps by itself at the end of a step
            if (lastSub)
            begin
                if (stepIdx == 7'(`LCD_FRAME_STEPS - 1))
                begin
                    stepIdx <= '0;
                end
                else
                begin
                    stepIdx <= stepIdx + 7'd1;
                end
            end
        end
    end

    // ==================================================
    // strobes
    // ==================================================
    assign stepStart = (subCnt == '0);
    assign enWindow  = subCnt[`LCD_STEP_BITS-1];  // second half of the step
    assign frameEnd  = lastSub && (stepIdx == 7'(`LCD_FRAME_STEPS - 1));

    // the wrap must happen before the index leaves the frame
    stepInFrame: assert property (@(posedge clk) disable iff (rst)
        stepIdx < 7'(`LCD_FRAME_STEPS));

endmodule

`default_nettype wire

// File: design/lcdStepDecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcdStepDecode import lcdPkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [6:0] stepIdx,
    input  wire logic       stepStart,
    input  wire lcdRow_t    upRow,
    input  wire lcdRow_t    doRow,
    output lcdOp_e          stepOp,
    output logic [3:0]      stepNibble
);

    lcdOp_e     nextOp;
    logic [3:0] nextNibble;
    logic [6:0] upRel;
    logic [6:0] doRel;

    // 4-bit init, two lines, display on, entry mode, clear
    function automatic logic [3:0] initNibble(input logic [6:0] idx);
        logic [3:0] nib;
        case (idx)
            7'd0, 7'd1, 7'd2: nib = 4'h3;
            7'd3, 7'd4:       nib = 4'h2;
            7'd5:             nib = 4'h8;
            7'd7:             nib = 4'h6;
            7'd9:             nib = 4'hC;
            7'd11:            nib = 4'h1;
            default:          nib = 4'h0;  // steps 6, 8 and 10
        endcase
        return nib;
    endfunction

    // bit 0 of rel picks the half, high nibble first
    function automatic logic [3:0] charNibble(input lcdRow_t row, input logic [6:0] rel);
        lcdChar_t   chr;
        logic [3:0] col;
        col = rel[4:1];
        chr = row[(`LCD_COLS - 1 - col) * 8 +: 8];
        return rel[0] ? chr[3:0] : chr[7:4];
    endfunction

    assign upRel = stepIdx - 7'(`LCD_UP_FIRST);
    assign doRel = stepIdx - 7'(`LCD_DO_FIRST);

    // ==================================================
    // step classification
    // ==================================================
    always_comb
    begin
        if (stepIdx < 7'(`LCD_UP_FIRST))
        begin
            nextOp     = opCmd;
            nextNibble = initNibble(stepIdx);
        end
        else if (stepIdx < 7'(`LCD_ADDR_FIRST))
        begin
            nextOp     = opData;
            nextNibble = charNibble(upRow, upRel);
        end
        else if (stepIdx < 7'(`LCD_DO_FIRST))
        begin
            nextOp = opCmd;
            // set DDRAM address 0x40, sent as C then 0
            nextNibble = (stepIdx == 7'(`LCD_ADDR_FIRST)) ? 4'hC : 4'h0;
        end
        else
        begin
            nextOp     = opData;
            nextNibble = charNibble(doRow, doRel);
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            stepOp     <= opIdle;
            stepNibble <= 4'h0;
        end
        else if (stepStart)
        begin
            stepOp     <= nextOp;  // held for the rest of the step
            stepNibble <= nextNibble;
        end
    end

endmodule

`default_nettype wire

// File: design/lcdBusDriver.sv
`timescale 1ns/1ps
`default_nettype none

module lcdBusDriver import lcdPkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       enWindow,
    input  wire lcdOp_e     stepOp,
    input  wire logic [3:0] stepNibble,
    output logic            e,
    output logic            rs,
    output logic            rw,
    output logic [3:0]      sf
);

    // ==================================================
    // pin registers
    // ==================================================
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            e  <= 1'b0;
            rs <= 1'b0;
            rw <= 1'b1;  // idle bus reads
            sf <= 4'h0;
        end
        else
        begin
            e  <= enWindow && (stepOp != opIdle);
            rs <= (stepOp == opData);
            rw <= (stepOp == opIdle);
            sf <= stepNibble;
        end
    end

    // ==================================================
    // bus checks
    // ==================================================

    // the display latches on the falling edge of e, so the data must settle
    // a cycle ahead and hold a cycle past it
    busStable: assert property (@(posedge clk) disable iff (rst)
        (e || $past(e)) |-> ($stable(sf) && $stable(rs)));

    // the busy flag is never read and rw is already low the cycle before e is high
    writeOnly: assert property (@(posedge clk) disable iff (rst)
        e |-> !$past(rw));

endmodule

`default_nettype wire

// File: design/lcdController.sv
`timescale 1ns/1ps
`default_nettype none

module lcdController import lcdPkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       charWrite,
    input  wire logic       charRow,
    input  wire logic [3:0] charCol,
    input  wire lcdChar_t   charCode,
    output logic            frameEnd,
    output logic            e,
    output logic            rs,
    output logic            rw,
    output logic [3:0]      sf
);

    lcdRow_t    upRow;
    lcdRow_t    doRow;
    logic [6:0] stepIdx;
    logic       stepStart;
    logic       enWindow;
    lcdOp_e     stepOp;
    logic [3:0] stepNibble;

    // ==================================================
    // text and pacing
    // ==================================================
    lcdRowStore lcdRowStore_inst
    (
        .clk       (clk),
        .rst       (rst),
        .charWrite (charWrite),
        .charRow   (charRow),
        .charCol   (charCol),
        .charCode  (charCode),
        .frameEnd  (frameEnd),
        .upRow     (upRow),
        .doRow     (doRow)
    );

    lcdStepTimer lcdStepTimer_inst
    (
        .clk       (clk),
        .rst       (rst),
        .stepIdx   (stepIdx),
        .stepStart (stepStart),
        .enWindow  (enWindow),
        .frameEnd  (frameEnd)
    );

    // ==================================================
    // decode and pins
    // ==================================================
    lcdStepDecode lcdStepDecode_inst
    (
        .clk        (clk),
        .rst        (rst),
        .stepIdx    (stepIdx),
        .stepStart  (stepStart),
        .upRow      (upRow),
        .doRow      (doRow),
        .stepOp     (stepOp),
        .stepNibble (stepNibble)
    );

    lcdBusDriver lcdBusDriver_inst
    (
        .clk        (clk),
        .rst        (rst),
        .enWindow   (enWindow),
        .stepOp     (stepOp),
        .stepNibble (stepNibble),
        .e          (e),
        .rs         (rs),
        .rw         (rw),
        .sf         (sf)
    );

endmodule

`default_nettype wire

// File: bench/lcdControllerTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lcd_config.svh"

module lcdControllerTb;

    localparam int maxRecords = 64;
    localparam int maxFrames  = 16;

    // init sequence of the display, one nibble per step
    localparam logic [3:0] initNibbles [0:11] =
        '{4'h3, 4'h3, 4'h3, 4'h2, 4'h2, 4'h8, 4'h0, 4'h6, 4'h0, 4'hC, 4'h0, 4'h1};

    logic       clk;
    logic       rst;
    logic       charWrite;
    logic       charRow;
    logic [3:0] charCol;
    logic [7:0] charCode;
    logic       frameEnd;
    logic       e;
    logic       rs;
    logic       rw;
    logic [3:0] sf;

    // records from the tests file, in file order
    logic       recIsFrame [0:maxRecords-1];
    logic       recRow [0:maxRecords-1];
    logic [3:0] recCol [0:maxRecords-1];
    logic [7:0] recCode [0:maxRecords-1];
    logic [7:0] upText [0:maxFrames-1][0:`LCD_COLS-1];
    logic [7:0] doText [0:maxFrames-1][0:`LCD_COLS-1];
    int         recordCount;
    int         frameCount;

    logic [3:0] nibQ[$];  // one entry per falling edge of e
    logic       rsQ[$];
    logic       eLast;
    int         pulseCount;
    int         framesSeen;
    int         cycleCount;
    int         limitCycles;
    int         checkedFrames;

    lcdController lcdController_inst
    (
        .clk       (clk),
        .rst       (rst),
        .charWrite (charWrite),
        .charRow   (charRow),
        .charCol   (charCol),
        .charCode  (charCode),
        .frameEnd  (frameEnd),
        .e         (e),
        .rs        (rs),
        .rw        (rw),
        .sf        (sf)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==================================================
    // reporting
    // ==================================================
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
        begin
            abortRun($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // ==================================================
    // tests file
    // ==================================================
    task automatic loadTests;
        int               fd;
        int               status;
        logic [7:0]       kind;
        logic [7:0]       rowVal;
        logic [7:0]       colVal;
        logic [7:0]       value;
        logic [8*120-1:0] restOfLine;
        recordCount = 0;
        frameCount  = 0;
        fd = $fopen("bench/lcd_tests.txt", "r");
        if (fd == 0)
        begin
            abortRun("could not open bench/lcd_tests.txt");
        end
        status = $fscanf(fd, " %s", kind);
        while (status == 1)
        begin
            if (recordCount >= maxRecords || frameCount >= maxFrames)
            begin
                abortRun("the tests file holds more records than the testbench can keep");
            end
            if (kind == "#")
            begin
                status = $fgets(restOfLine, fd);  // comment line
            end
            else if (kind == "W")
            begin
                status = $fscanf(fd, " %h %h %h", rowVal, colVal, value);
                if (status != 3)
                begin
                    abortRun("a write record in the tests file is incomplete");
                end
                recIsFrame[recordCount] = 1'b0;
                recRow[recordCount]     = rowVal[0];
                recCol[recordCount]     = colVal[3:0];
                recCode[recordCount]    = value;
                recordCount++;
            end
            else if (kind == "F")
            begin
                for (int i = 0; i < 2 * `LCD_COLS; i++)
                begin
                    status = $fscanf(fd, " %h", value);
                    if (status != 1)
                    begin
                        abortRun("a frame record in the tests file is incomplete");
                    end
                    if (i < `LCD_COLS)
                    begin
                        upText[frameCount][i] = value;
                    end
                    else
                    begin
                        doText[frameCount][i - `LCD_COLS] = value;
                    end
                end
                recIsFrame[recordCount] = 1'b1;
                recordCount++;
                frameCount++;
            end
            else
            begin
                abortRun("the tests file holds a record of unknown kind");
            end
            status = $fscanf(fd, " %s", kind);
        end
        $fclose(fd);
    endtask

    // ==================================================
    // expected bus stream
    // ==================================================
    // returns {rs, nibble} for one step of a frame
    function automatic logic [4:0] expectedBus(input int frame, input int step);
        logic [7:0] chr;
        logic [4:0] result;
        int         rel;
        if (step < 12)
        begin
            result = {1'b0, initNibbles[step]};
        end
        else if (step < 44 || step >= 46)
        begin
            rel = (step < 44) ? step - 12 : step - 46;
            chr = (step < 44) ? upText[frame][rel / 2] : doText[frame][rel / 2];
            result = {1'b1, (rel % 2 == 1) ? chr[3:0] : chr[7:4]};  // high nibble first
        end
        else
        begin
            result = (step == 44) ? 5'h0C : 5'h00;
        end
        return result;
    endfunction

    task automatic waitForFrame(input int frame);
        while (nibQ.size() < (frame + 1) * `LCD_FRAME_STEPS)
        begin
            @(posedge clk);
        end
    endtask

    task automatic checkFrame(input int frame);
        int         base;
        logic [4:0] exp;
        base = frame * `LCD_FRAME_STEPS;
        for (int s = 0; s < `LCD_FRAME_STEPS; s++)
        begin
            exp = expectedBus(frame, s);
            checkValue($sformatf("rs in frame %0d step %0d", frame, s),
                       32'(rsQ[base + s]), 32'(exp[4]));
            checkValue($sformatf("sf in frame %0d step %0d", frame, s),
                       32'(nibQ[base + s]), 32'(exp[3:0]));
        end
    endtask

    task automatic writeChar(input logic row, input logic [3:0] col, input logic [7:0] code);
        @(posedge clk);
        charWrite <= 1'b1;
        charRow   <= row;
        charCol   <= col;
        charCode  <= code;
        @(posedge clk);
        charWrite <= 1'b0;
    endtask

    // ==================================================
    // bus monitor and timeout
    // ==================================================
    initial
    begin
        eLast      = 1'b0;
        pulseCount = 0;
        framesSeen = 0;
        cycleCount = 0;
    end

    // outputs settle after the rising edge, so the falling edge is a quiet place to look
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (eLast && !e)
            begin
                checkValue("rw at falling e", 32'(rw), 32'd0);
                nibQ.push_back(sf);
                rsQ.push_back(rs);
                pulseCount++;
            end
            if (frameEnd)
            begin
                if (framesSeen > 0)
                begin
                    checkValue("e pulses per frame", 32'(pulseCount), 32'(`LCD_FRAME_STEPS));
                end
                pulseCount = 0;
                framesSeen++;
            end
            eLast = e;
        end
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (limitCycles > 0 && cycleCount >= limitCycles)
        begin
            abortRun($sformatf("timeout after %0d cycles, the bus stream stalled", cycleCount));
        end
    end

    // ==================================================
    // main sequence
    // ==================================================
    initial
    begin
        rst         <= 1'b1;
        charWrite   <= 1'b0;
        charRow     <= 1'b0;
        charCol     <= 4'h0;
        charCode    <= 8'h00;
        limitCycles = 0;
        loadTests();
        limitCycles = (frameCount + 2) * `LCD_FRAME_STEPS * (1 << `LCD_STEP_BITS);

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("e after reset", 32'(e), 32'd0);
        checkValue("rw after reset", 32'(rw), 32'd1);
        checkValue("rs after reset", 32'(rs), 32'd0);

        checkedFrames = 0;
        for (int r = 0; r < recordCount; r++)
        begin
            if (recIsFrame[r])
            begin
                waitForFrame(checkedFrames);  // the frame has ended and all 78 nibbles are in
                checkFrame(checkedFrames);
                checkedFrames++;
            end
            else
            begin
                writeChar(recRow[r], recCol[r], recCode[r]);
            end
        end

        if (checkedFrames == 0)
        begin
            abortRun("the tests file holds no frame record");
        end
        else
        begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: bench/lcd_tests.txt
# W row col code : write one character, row 0 upper and 1 lower, all values hex
# F then 16 upper and 16 lower codes in hex : expected text of the next frame to end
F 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
  20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
W 0 0 48
W 0 1 69
W 0 F 21
W 1 0 4C
W 1 7 3A
W 1 F 7E
F 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
  20 20 20 20 20 20 20 20 20 20 20 20 20 20 20 20
F 48 69 20 20 20 20 20 20 20 20 20 20 20 20 20 21
  4C 20 20 20 20 20 20 3A 20 20 20 20 20 20 20 7E
W 0 1 61
W 1 3 35
F 48 69 20 20 20 20 20 20 20 20 20 20 20 20 20 21
  4C 20 20 20 20 20 20 3A 20 20 20 20 20 20 20 7E
F 48 61 20 20 20 20 20 20 20 20 20 20 20 20 20 21
  4C 20 20 35 20 20 20 3A 20 20 20 20 20 20 20 7E

// File: build.f
+incdir+design
design/lcdPkg.sv
design/lcdRowStore.sv
design/lcdStepTimer.sv
design/lcdStepDecode.sv
design/lcdBusDriver.sv
design/lcdController.sv
bench/lcdControllerTb.sv

// File: run.sh
#!/bin/sh
# compile with Verilator and run, then look for the fail message in the log
rm -rf obj_dir sim.log
verilator --binary --timing -f build.f --top-module lcdControllerTb \
    && ./obj_dir/VlcdControllerTb > sim.log 2>&1 \
    || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
exit 0
